// ==== tb.f ====
tinyriscv_pkg.sv
rib.sv
sram.sv
timer.sv
gpio.sv
soc_bus_top.sv
tb_soc_bus.sv

// ==== tb_soc_bus.sv ====
// RIB bus subsystem testbench
`timescale 1ns/1ns
`default_nettype none

module tb_soc_bus;
    import tinyriscv_pkg::*;

    localparam logic [31:0] nop_word = 32'h0000_0013;  // master 1 idle read

    logic        clk;
    logic        arst_n_i;
    logic [31:0] m_addr [4];
    logic [31:0] m_wdata [4];
    logic [3:0]  m_req;
    logic [3:0]  m_we;
    wire  [31:0] m0_rdata, m1_rdata, m2_rdata, m3_rdata;
    wire         hold_flag;
    wire         timer_irq;
    wire  [31:0] gpio_out;
    logic [31:0] gpio_in;
    logic [15:0] lfsr_q;           // random source state
    logic [31:0] ram_model [256];  // expected ram contents
    logic [31:0] rom_model [256];  // expected store contents
    int          checks;
    int          errors;

    soc_bus_top dut0 (
        .clk (clk), .arst_n_i (arst_n_i),
        .m0_addr_i (m_addr[0]), .m0_data_i (m_wdata[0]), .m0_data_o (m0_rdata),
        .m0_req_i  (m_req[0]),  .m0_we_i   (m_we[0]),
        .m1_addr_i (m_addr[1]), .m1_data_i (m_wdata[1]), .m1_data_o (m1_rdata),
        .m1_req_i  (m_req[1]),  .m1_we_i   (m_we[1]),
        .m2_addr_i (m_addr[2]), .m2_data_i (m_wdata[2]), .m2_data_o (m2_rdata),
        .m2_req_i  (m_req[2]),  .m2_we_i   (m_we[2]),
        .m3_addr_i (m_addr[3]), .m3_data_i (m_wdata[3]), .m3_data_o (m3_rdata),
        .m3_req_i  (m_req[3]),  .m3_we_i   (m_we[3]),
        .hold_flag_o (hold_flag), .timer_irq_o (timer_irq),
        .gpio_o (gpio_out), .gpio_i (gpio_in)
    );

    always #50 clk = ~clk;  // 100 ns period

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            w[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);  // one step per bit
        end
    endtask

    function automatic logic [31:0] map_addr(input logic [3:0] region, input logic [31:0] off);
        map_addr = {region, off[27:0]};
    endfunction

    function automatic logic [31:0] rdata_of(input int m);
        case (m)
            0:       rdata_of = m0_rdata;
            1:       rdata_of = m1_rdata;
            2:       rdata_of = m2_rdata;
            default: rdata_of = m3_rdata;
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s expected %08h got %08h", $time, name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int base);
        $display("%s test done, %0d errors", name, errors - base);
    endtask

    // new cycle with all requests dropped
    task automatic start_cycle();
        @(posedge clk);
        #1;
        m_req = 4'b0;
        m_we  = 4'b0;
    endtask

    task automatic bus_access(input int m, input logic [31:0] addr, input logic we,
                              input logic [31:0] data);
        start_cycle();
        m_addr[m]  = addr;
        m_wdata[m] = data;
        m_req[m]   = 1'b1;
        m_we[m]    = we;
        @(negedge clk);
        compare_word("hold_flag_o", {31'b0, m != 1}, {31'b0, hold_flag});
    endtask

    task automatic bus_write(input int m, input logic [31:0] addr, input logic [31:0] data);
        bus_access(m, addr, 1'b1, data);
        if (addr[31:28] == SlaveRam) begin
            ram_model[addr[9:2]] = data;
        end else if (addr[31:28] == SlaveRom) begin
            rom_model[addr[9:2]] = data;
        end
    endtask

    task automatic bus_read(input int m, input logic [31:0] addr, input logic [31:0] expected);
        bus_access(m, addr, 1'b0, ZeroWord);
        compare_word($sformatf("m%0d_data_o", m), expected, rdata_of(m));
    endtask

    task automatic memory_test();
        logic [31:0] off;
        logic [31:0] w;
        int          base;
        base = errors;
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 4; i++) begin
                off = (m * 4 + i) * 4;
                rand_word(w);
                bus_write(m, map_addr(SlaveRam, off), w);
                rand_word(w);
                bus_write(m, map_addr(SlaveRom, off), w);  // same offset in the other slave
            end
        end
        for (int m = 0; m < 4; m++) begin
            for (int i = 0; i < 16; i++) begin
                bus_read(m, map_addr(SlaveRam, i * 4), ram_model[i]);
                bus_read(m, map_addr(SlaveRom, i * 4), rom_model[i]);
            end
        end
        finish_test("memory", base);
    endtask

    // masters in mask write ram words 64..67 in one cycle
    task automatic contend(input logic [3:0] mask);
        logic [31:0] w [4];
        int          win;
        win = mask[3] ? 3 : mask[0] ? 0 : mask[2] ? 2 : 1;
        start_cycle();
        for (int m = 0; m < 4; m++) begin
            rand_word(w[m]);
            m_addr[m]  = map_addr(SlaveRam, 32'h100 + m * 4);
            m_wdata[m] = w[m];
            m_req[m]   = mask[m];
            m_we[m]    = mask[m];
        end
        @(negedge clk);
        compare_word("hold_flag_o", {31'b0, win != 1}, {31'b0, hold_flag});
        for (int m = 0; m < 4; m++) begin
            if (mask[m] && m != win) begin
                compare_word($sformatf("m%0d_data_o", m), (m == 1) ? nop_word : ZeroWord,
                             rdata_of(m));
            end
        end
        ram_model[64 + win] = w[win];  // only the winner lands
        for (int m = 0; m < 4; m++) begin
            bus_read(0, map_addr(SlaveRam, 32'h100 + m * 4), ram_model[64 + m]);
        end
    endtask

    task automatic priority_test();
        logic [31:0] w;
        int          base;
        base = errors;
        for (int m = 0; m < 4; m++) begin
            rand_word(w);
            bus_write(2, map_addr(SlaveRam, 32'h100 + m * 4), w);
        end
        contend(4'b1111);
        contend(4'b0101);
        contend(4'b0110);
        contend(4'b1010);
        contend(4'b0011);
        finish_test("priority", base);
    endtask

    task automatic unmapped_test();
        logic [31:0] w;
        int          base;
        base = errors;
        rand_word(w);
        bus_write(0, 32'h5000_0000, w);
        bus_write(1, 32'h5000_0004, ~w);
        bus_write(3, 32'h5000_0008, w);  // timer compare offset
        bus_read(0, 32'h5000_0000, ZeroWord);
        bus_read(1, 32'h5000_0004, nop_word);
        bus_read(0, map_addr(SlaveRam, 32'h0), ram_model[0]);
        bus_read(0, map_addr(SlaveRam, 32'h4), ram_model[1]);
        bus_read(2, map_addr(SlaveRom, 32'h0), rom_model[0]);
        bus_read(2, map_addr(SlaveRom, 32'h4), rom_model[1]);
        bus_read(3, map_addr(SlaveTimer, TimerCtrl), ZeroWord);
        bus_read(3, map_addr(SlaveTimer, TimerCount), ZeroWord);
        bus_read(3, map_addr(SlaveTimer, TimerValue), ZeroWord);
        bus_read(0, map_addr(SlaveGpio, GpioOut), ZeroWord);
        compare_word("gpio_o", ZeroWord, gpio_out);
        finish_test("unmapped", base);
    endtask

    task automatic gpio_test();
        logic [31:0] w;
        logic [31:0] w_in;
        int          base;
        base = errors;
        rand_word(w);
        bus_write(0, map_addr(SlaveGpio, GpioOut), w);
        compare_word("gpio_o", ZeroWord, gpio_out);  // not before the edge
        start_cycle();
        @(negedge clk);
        compare_word("gpio_o", w, gpio_out);
        rand_word(w_in);
        start_cycle();
        gpio_in = w_in;
        repeat (3) @(posedge clk);  // through the synchroniser
        bus_read(2, map_addr(SlaveGpio, GpioIn), w_in);
        bus_read(1, map_addr(SlaveGpio, GpioOut), w);
        finish_test("gpio", base);
    endtask

    task automatic timer_test();
        logic seen;
        int   base;
        base = errors;
        seen = 1'b0;
        bus_write(3, map_addr(SlaveTimer, TimerValue), 32'd5);
        bus_read(3, map_addr(SlaveTimer, TimerValue), 32'd5);
        bus_write(3, map_addr(SlaveTimer, TimerCtrl), 32'h3);  // en and irq en
        start_cycle();
        for (int n = 0; n < 200 && !seen; n++) begin
            @(negedge clk);
            seen = timer_irq;
        end
        if (!seen) begin
            errors++;
            $display("timer interrupt did not rise within 200 cycles");
        end
        bus_read(0, map_addr(SlaveTimer, TimerCtrl), 32'h7);
        bus_write(0, map_addr(SlaveTimer, TimerCtrl), 32'h6);  // clear pending and stop
        start_cycle();
        @(negedge clk);
        compare_word("timer_irq_o", ZeroWord, {31'b0, timer_irq});
        bus_read(0, map_addr(SlaveTimer, TimerCtrl), 32'h2);
        finish_test("timer", base);
    endtask

    initial begin
        int base;
        clk      = 1'b0;
        arst_n_i = 1'b0;
        m_req    = 4'b0;
        m_we     = 4'b0;
        gpio_in  = ZeroWord;
        for (int i = 0; i < 4; i++) begin
            m_addr[i]  = ZeroWord;
            m_wdata[i] = ZeroWord;
        end
        lfsr_q = 16'd18323;
        checks = 0;
        errors = 0;
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        base = errors;
        @(negedge clk);
        compare_word("gpio_o", ZeroWord, gpio_out);
        compare_word("timer_irq_o", ZeroWord, {31'b0, timer_irq});
        finish_test("reset", base);
        memory_test();
        priority_test();
        unmapped_test();
        gpio_test();
        timer_test();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_bus_top.sv ====
// RIB bus subsystem top
`timescale 1ns/1ns
`default_nettype none

module soc_bus_top (
    input  wire                           clk,
    input  wire                           arst_n_i,
    // master 0
    input  wire tinyriscv_pkg::mem_addr_t m0_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m0_data_i,
    output wire tinyriscv_pkg::mem_data_t m0_data_o,
    input  wire                           m0_req_i,
    input  wire                           m0_we_i,
    // master 1
    input  wire tinyriscv_pkg::mem_addr_t m1_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m1_data_i,
    output wire tinyriscv_pkg::mem_data_t m1_data_o,
    input  wire                           m1_req_i,
    input  wire                           m1_we_i,
    // master 2
    input  wire tinyriscv_pkg::mem_addr_t m2_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m2_data_i,
    output wire tinyriscv_pkg::mem_data_t m2_data_o,
    input  wire                           m2_req_i,
    input  wire                           m2_we_i,
    // master 3
    input  wire tinyriscv_pkg::mem_addr_t m3_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m3_data_i,
    output wire tinyriscv_pkg::mem_data_t m3_data_o,
    input  wire                           m3_req_i,
    input  wire                           m3_we_i,

    output wire                           hold_flag_o,
    output wire                           timer_irq_o,
    output wire tinyriscv_pkg::mem_data_t gpio_o,
    input  wire tinyriscv_pkg::mem_data_t gpio_i
);
    import tinyriscv_pkg::*;

    // slave side of the bus
    mem_addr_t s0_addr, s1_addr, s2_addr, s3_addr;
    mem_data_t s0_wdata, s1_wdata, s2_wdata, s3_wdata;
    mem_data_t s0_rdata, s1_rdata, s2_rdata, s3_rdata;
    logic      s0_we, s1_we, s2_we, s3_we;

    rib u_rib (
        .m0_addr_i (m0_addr_i), .m0_data_i (m0_data_i), .m0_data_o (m0_data_o),
        .m0_req_i  (m0_req_i),  .m0_we_i   (m0_we_i),
        .m1_addr_i (m1_addr_i), .m1_data_i (m1_data_i), .m1_data_o (m1_data_o),
        .m1_req_i  (m1_req_i),  .m1_we_i   (m1_we_i),
        .m2_addr_i (m2_addr_i), .m2_data_i (m2_data_i), .m2_data_o (m2_data_o),
        .m2_req_i  (m2_req_i),  .m2_we_i   (m2_we_i),
        .m3_addr_i (m3_addr_i), .m3_data_i (m3_data_i), .m3_data_o (m3_data_o),
        .m3_req_i  (m3_req_i),  .m3_we_i   (m3_we_i),
        .s0_addr_o (s0_addr),   .s0_data_o (s0_wdata),  .s0_data_i (s0_rdata),
        .s0_we_o   (s0_we),
        .s1_addr_o (s1_addr),   .s1_data_o (s1_wdata),  .s1_data_i (s1_rdata),
        .s1_we_o   (s1_we),
        .s2_addr_o (s2_addr),   .s2_data_o (s2_wdata),  .s2_data_i (s2_rdata),
        .s2_we_o   (s2_we),
        .s3_addr_o (s3_addr),   .s3_data_o (s3_wdata),  .s3_data_i (s3_rdata),
        .s3_we_o   (s3_we),
        .hold_flag_o (hold_flag_o)
    );

    // instruction store
    sram #(.Depth(RomDepth)) u_rom (
        .clk    (clk),
        .addr_i (s0_addr),
        .data_i (s0_wdata),
        .we_i   (s0_we),
        .data_o (s0_rdata)
    );

    // data ram
    sram #(.Depth(RamDepth)) u_ram (
        .clk    (clk),
        .addr_i (s1_addr),
        .data_i (s1_wdata),
        .we_i   (s1_we),
        .data_o (s1_rdata)
    );

    timer u_timer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .addr_i      (s2_addr),
        .data_i      (s2_wdata),
        .we_i        (s2_we),
        .data_o      (s2_rdata),
        .timer_irq_o (timer_irq_o)
    );

    gpio u_gpio (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .addr_i   (s3_addr),
        .data_i   (s3_wdata),
        .we_i     (s3_we),
        .data_o   (s3_rdata),
        .gpio_o   (gpio_o),
        .gpio_i   (gpio_i)
    );

endmodule

`default_nettype wire

// ==== gpio.sv ====
// Memory-mapped GPIO
`timescale 1ns/1ns
`default_nettype none

module gpio (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire tinyriscv_pkg::mem_addr_t addr_i,
    input  wire tinyriscv_pkg::mem_data_t data_i,
    input  wire                           we_i,
    output tinyriscv_pkg::mem_data_t      data_o,
    output tinyriscv_pkg::mem_data_t      gpio_o,
    input  wire tinyriscv_pkg::mem_data_t gpio_i
);
    import tinyriscv_pkg::*;

    mem_data_t out_q;   // output register
    mem_data_t meta_q;  // first sync stage
    mem_data_t sync_q;  // second sync stage

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_q <= ZeroWord;
        end else if ((we_i == WriteEnable) && (addr_i == GpioOut)) begin
            out_q <= data_i;
        end
    end

    // pins are asynchronous to clk
    always_ff @(posedge clk) begin
        meta_q <= gpio_i;
        sync_q <= meta_q;
    end

    always_comb begin
        case (addr_i)
            GpioOut: data_o = out_q;
            GpioIn:  data_o = sync_q;
            default: data_o = ZeroWord;
        endcase
    end

    assign gpio_o = out_q;

endmodule

`default_nettype wire

// ==== timer.sv ====
// Memory-mapped timer
`timescale 1ns/1ns
`default_nettype none

module timer (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire tinyriscv_pkg::mem_addr_t addr_i,
    input  wire tinyriscv_pkg::mem_data_t data_i,
    input  wire                           we_i,
    output tinyriscv_pkg::mem_data_t      data_o,
    output logic                          timer_irq_o
);
    import tinyriscv_pkg::*;

    mem_data_t ctrl_q;   // bit 0 en, bit 1 irq en, bit 2 pending
    mem_data_t count_q;  // running count
    mem_data_t value_q;  // compare value
    logic      ctrl_wr;
    logic      value_wr;
    logic      hit;      // count reached compare
    logic      pend_clr; // write one to clear

    assign ctrl_wr  = (we_i == WriteEnable) && (addr_i == TimerCtrl);
    assign value_wr = (we_i == WriteEnable) && (addr_i == TimerValue);
    assign hit      = ctrl_q[0] && (count_q == value_q);
    assign pend_clr = ctrl_wr && data_i[2];

    // counter, wraps to zero on a match
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            count_q <= ZeroWord;
        end else if (hit) begin
            count_q <= ZeroWord;
        end else if (ctrl_q[0]) begin
            count_q <= count_q + 1'b1;
        end
    end

    // ctrl, pending is sticky until cleared by software
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= ZeroWord;
        end else begin
            if (ctrl_wr) begin
                ctrl_q[MemBus-1:3] <= data_i[MemBus-1:3];
                ctrl_q[1:0]        <= data_i[1:0];
            end
            if (pend_clr) begin
                ctrl_q[2] <= 1'b0;  // clear beats a new match
            end else if (hit) begin
                ctrl_q[2] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            value_q <= ZeroWord;
        end else if (value_wr) begin
            value_q <= data_i;
        end
    end

    // register readback
    always_comb begin
        case (addr_i)
            TimerCtrl:  data_o = ctrl_q;
            TimerCount: data_o = count_q;
            TimerValue: data_o = value_q;
            default:    data_o = ZeroWord;
        endcase
    end

    assign timer_irq_o = ctrl_q[2] & ctrl_q[1];  // level irq

endmodule

`default_nettype wire

// ==== sram.sv ====
// Word memory
`timescale 1ns/1ns
`default_nettype none

module sram #(
    parameter int Depth = 256  // number of words
) (
    input  wire                           clk,
    input  wire tinyriscv_pkg::mem_addr_t addr_i,  // byte offset
    input  wire tinyriscv_pkg::mem_data_t data_i,
    input  wire                           we_i,
    output tinyriscv_pkg::mem_data_t      data_o
);
    import tinyriscv_pkg::*;

    mem_data_t mem_q [Depth];  // storage
    mem_addr_t word_idx;        // word index, wraps at Depth

    assign word_idx = (addr_i >> 2) % Depth;

    // write lands on the edge closing the access
    always_ff @(posedge clk) begin
        if (we_i == WriteEnable) begin
            mem_q[word_idx] <= data_i;
        end
    end

    assign data_o = mem_q[word_idx];  // read in the same cycle

endmodule

`default_nettype wire

// ==== rib.sv ====
// RIB system bus
`timescale 1ns/1ns
`default_nettype none

module rib (
    // master 0, core data port
    input  wire tinyriscv_pkg::mem_addr_t m0_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m0_data_i,
    output tinyriscv_pkg::mem_data_t      m0_data_o,
    input  wire                           m0_req_i,
    input  wire                           m0_we_i,
    // master 1, core fetch port
    input  wire tinyriscv_pkg::mem_addr_t m1_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m1_data_i,
    output tinyriscv_pkg::mem_data_t      m1_data_o,
    input  wire                           m1_req_i,
    input  wire                           m1_we_i,
    // master 2, debug port
    input  wire tinyriscv_pkg::mem_addr_t m2_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m2_data_i,
    output tinyriscv_pkg::mem_data_t      m2_data_o,
    input  wire                           m2_req_i,
    input  wire                           m2_we_i,
    // master 3, serial loader
    input  wire tinyriscv_pkg::mem_addr_t m3_addr_i,
    input  wire tinyriscv_pkg::mem_data_t m3_data_i,
    output tinyriscv_pkg::mem_data_t      m3_data_o,
    input  wire                           m3_req_i,
    input  wire                           m3_we_i,
    // slave 0, instruction store
    output tinyriscv_pkg::mem_addr_t      s0_addr_o,
    output tinyriscv_pkg::mem_data_t      s0_data_o,
    input  wire tinyriscv_pkg::mem_data_t s0_data_i,
    output logic                          s0_we_o,
    // slave 1, data ram
    output tinyriscv_pkg::mem_addr_t      s1_addr_o,
    output tinyriscv_pkg::mem_data_t      s1_data_o,
    input  wire tinyriscv_pkg::mem_data_t s1_data_i,
    output logic                          s1_we_o,
    // slave 2, timer
    output tinyriscv_pkg::mem_addr_t      s2_addr_o,
    output tinyriscv_pkg::mem_data_t      s2_data_o,
    input  wire tinyriscv_pkg::mem_data_t s2_data_i,
    output logic                          s2_we_o,
    // slave 3, gpio
    output tinyriscv_pkg::mem_addr_t      s3_addr_o,
    output tinyriscv_pkg::mem_data_t      s3_data_o,
    input  wire tinyriscv_pkg::mem_data_t s3_data_i,
    output logic                          s3_we_o,

    output logic                          hold_flag_o  // stalls the pipeline
);
    import tinyriscv_pkg::*;

    logic [1:0] grant;      // index of the owning master
    mem_addr_t  sel_addr;   // owner's address
    mem_addr_t  sel_offs;   // address with region nibble cleared
    mem_data_t  sel_wdata;  // owner's write data
    logic       sel_we;     // owner's write strobe
    mem_data_t  sel_rdata;  // read data of the addressed slave
    logic       sel_hit;    // owner hit a mapped region

    // fixed priority 3 > 0 > 2 > 1, master 1 is the fallback owner
    always_comb begin
        if (m3_req_i) begin
            grant       = 2'd3;
            hold_flag_o = HoldEnable;
        end else if (m0_req_i) begin
            grant       = 2'd0;
            hold_flag_o = HoldEnable;
        end else if (m2_req_i) begin
            grant       = 2'd2;
            hold_flag_o = HoldEnable;
        end else begin
            grant       = 2'd1;  // owns the bus even without a request
            hold_flag_o = HoldDisable;
        end
    end

    // steer the owner onto the shared bus
    always_comb begin
        case (grant)
            2'd0: begin
                sel_addr  = m0_addr_i;
                sel_wdata = m0_data_i;
                sel_we    = m0_we_i;
            end
            2'd2: begin
                sel_addr  = m2_addr_i;
                sel_wdata = m2_data_i;
                sel_we    = m2_we_i;
            end
            2'd3: begin
                sel_addr  = m3_addr_i;
                sel_wdata = m3_data_i;
                sel_we    = m3_we_i;
            end
            default: begin
                sel_addr  = m1_addr_i;
                sel_wdata = m1_data_i;
                sel_we    = m1_we_i;
            end
        endcase
    end

    assign sel_offs = {4'h0, sel_addr[MemAddrBus-5:0]};

    // region decode, only the addressed slave sees the access
    always_comb begin
        s0_addr_o = ZeroWord;
        s1_addr_o = ZeroWord;
        s2_addr_o = ZeroWord;
        s3_addr_o = ZeroWord;
        s0_data_o = ZeroWord;
        s1_data_o = ZeroWord;
        s2_data_o = ZeroWord;
        s3_data_o = ZeroWord;
        s0_we_o   = WriteDisable;
        s1_we_o   = WriteDisable;
        s2_we_o   = WriteDisable;
        s3_we_o   = WriteDisable;
        sel_rdata = ZeroWord;
        sel_hit   = 1'b1;
        case (sel_addr[MemAddrBus-1 -: 4])
            SlaveRom: begin
                s0_addr_o = sel_offs;
                s0_data_o = sel_wdata;
                s0_we_o   = sel_we;
                sel_rdata = s0_data_i;
            end
            SlaveRam: begin
                s1_addr_o = sel_offs;
                s1_data_o = sel_wdata;
                s1_we_o   = sel_we;
                sel_rdata = s1_data_i;
            end
            SlaveTimer: begin
                s2_addr_o = sel_offs;
                s2_data_o = sel_wdata;
                s2_we_o   = sel_we;
                sel_rdata = s2_data_i;
            end
            SlaveGpio: begin
                s3_addr_o = sel_offs;
                s3_data_o = sel_wdata;
                s3_we_o   = sel_we;
                sel_rdata = s3_data_i;
            end
            default: sel_hit = 1'b0;  // unmapped, write dropped
        endcase
    end

    // read data back to the owner, everyone else idles
    always_comb begin
        m0_data_o = ZeroWord;
        m1_data_o = INST_NOP;
        m2_data_o = ZeroWord;
        m3_data_o = ZeroWord;
        if (sel_hit) begin
            case (grant)
                2'd0:    m0_data_o = sel_rdata;
                2'd2:    m2_data_o = sel_rdata;
                2'd3:    m3_data_o = sel_rdata;
                default: m1_data_o = sel_rdata;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tinyriscv_pkg.sv ====
// RIB bus shared definitions
`default_nettype none

package tinyriscv_pkg;

    // bus widths
    localparam int MemAddrBus = 32;  // address bits
    localparam int MemBus     = 32;  // data bits

    typedef logic [MemAddrBus-1:0] mem_addr_t;  // one bus address
    typedef logic [MemBus-1:0]     mem_data_t;  // one bus data word

    // fixed words
    localparam mem_data_t ZeroWord = 32'h0000_0000;
    localparam mem_data_t INST_NOP = 32'h0000_0013;  // addi x0, x0, 0

    // pipeline hold levels
    localparam logic HoldEnable  = 1'b1;
    localparam logic HoldDisable = 1'b0;

    // write strobe levels
    localparam logic WriteEnable  = 1'b1;
    localparam logic WriteDisable = 1'b0;

    // region codes, matched against address bits 31:28
    localparam logic [3:0] SlaveRom   = 4'h0;  // instruction store
    localparam logic [3:0] SlaveRam   = 4'h1;  // data ram
    localparam logic [3:0] SlaveTimer = 4'h2;  // timer
    localparam logic [3:0] SlaveGpio  = 4'h3;  // gpio

    // memory sizes in words
    localparam int RomDepth = 256;
    localparam int RamDepth = 256;

    // timer register offsets
    localparam mem_addr_t TimerCtrl  = 32'h0000_0000;  // en, irq en, pending
    localparam mem_addr_t TimerCount = 32'h0000_0004;  // running count
    localparam mem_addr_t TimerValue = 32'h0000_0008;  // compare value

    // gpio register offsets
    localparam mem_addr_t GpioOut = 32'h0000_0000;  // output register
    localparam mem_addr_t GpioIn  = 32'h0000_0004;  // synchronised input

endpackage

`default_nettype wire
